/* soc_periph_params.svh */
`ifndef SOC_PERIPH_PARAMS_SVH
`define SOC_PERIPH_PARAMS_SVH

// apb slave port
`define APB_ADDR_W       12
`define APB_DATA_W       32
`define APB_SLV_SEL_LSB  8   // paddr[11:8] picks the block

// timer register map
`define TIMER_CFG_OFS    8'h00
`define TIMER_CNT_OFS    8'h04
`define TIMER_CMP_OFS    8'h08

// event generator register map
`define EVT_MASK_OFS     8'h00
`define EVT_SW_OFS       8'h04
`define EVT_PEND_OFS     8'h08

// event sources, peripherals sit in the low bits
`define NUM_EVT            16
`define NUM_PER_EVT        8
`define EVT_IDX_TIMER      8
`define EVT_IDX_REF_RISE   9
`define EVT_IDX_REF_FALL   10
`define FC_IDX_FIFO_VALID  11   // fc word bit, fifo not empty

`define EVNT_WIDTH       8
`define EVT_FIFO_DEPTH   4

`endif

/* soc_periph_pkg.sv */
`default_nettype none

`include "soc_periph_params.svh"

package soc_periph_pkg;

  // apb request, master to slave
  typedef struct packed {
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`APB_ADDR_W-1:0] paddr;
    logic [`APB_DATA_W-1:0] pwdata;
  } apb_req_t;

  // apb response, slave to master
  typedef struct packed {
    logic [`APB_DATA_W-1:0] prdata;
    logic                   pready;
    logic                   pslverr;
  } apb_rsp_t;

  // one bit per event source
  typedef logic [`NUM_EVT-1:0] evt_vec_t;

  // dispatched event number
  typedef logic [`EVNT_WIDTH-1:0] event_id_t;

  // raw fc event word
  typedef logic [`NUM_EVT-1:0] fc_events_t;

endpackage

`default_nettype wire

/* apb_periph_decode.sv */
`timescale 1ns/10ps
`default_nettype none

`include "soc_periph_params.svh"

module apb_periph_decode import soc_periph_pkg::*; (
  input  apb_req_t apb_req_i,     // from the bus master
  output apb_rsp_t apb_rsp_o,
  output apb_req_t timer_req_o,   // slot 0
  input  apb_rsp_t timer_rsp_i,
  output apb_req_t evt_req_o,     // slot 1
  input  apb_rsp_t evt_rsp_i
);

  localparam int SEL_W = `APB_ADDR_W - `APB_SLV_SEL_LSB;
  localparam logic [SEL_W-1:0] SEL_TIMER = SEL_W'(0);
  localparam logic [SEL_W-1:0] SEL_EVT   = SEL_W'(1);

  logic [SEL_W-1:0] blk_sel;   // block field of paddr

  assign blk_sel = apb_req_i.paddr[`APB_ADDR_W-1:`APB_SLV_SEL_LSB];

  // same request to both blocks, only psel is qualified
  always_comb begin
    timer_req_o      = apb_req_i;
    timer_req_o.psel = apb_req_i.psel & (blk_sel == SEL_TIMER);
    evt_req_o        = apb_req_i;
    evt_req_o.psel   = apb_req_i.psel & (blk_sel == SEL_EVT);
  end

  // response mux
  always_comb begin
    case (blk_sel)
      SEL_TIMER: apb_rsp_o = timer_rsp_i;
      SEL_EVT:   apb_rsp_o = evt_rsp_i;
      default: begin
        // hole in the map
        apb_rsp_o.prdata  = '0;
        apb_rsp_o.pready  = 1'b1;             // zero wait states here too
        apb_rsp_o.pslverr = apb_req_i.psel;   // error only while selected
      end
    endcase
  end

endmodule

`default_nettype wire

/* ref_clk_edge_detect.sv */
`timescale 1ns/10ps
`default_nettype none

module ref_clk_edge_detect (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic ref_clk_i,   // slow reference, async to clk_i
  output logic rise_o,
  output logic fall_o
);

  logic [1:0] sync_q;   // two-flop synchronizer
  logic       hist_q;   // last synchronized level

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q <= '0;
      hist_q <= 1'b0;
      rise_o <= 1'b0;
      fall_o <= 1'b0;
    end else begin
      sync_q <= {sync_q[0], ref_clk_i};
      hist_q <= sync_q[1];
      // registered pulses, third clock after the pin moves
      rise_o <= sync_q[1] & ~hist_q;
      fall_o <= ~sync_q[1] & hist_q;
    end
  end

endmodule

`default_nettype wire

/* soc_timer_unit.sv */
`timescale 1ns/10ps
`default_nettype none

`include "soc_periph_params.svh"

module soc_timer_unit import soc_periph_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  apb_req_t apb_req_i,
  output apb_rsp_t apb_rsp_o,
  input  logic     tick_i,         // ref clk rise pulse
  input  logic     stop_timer_i,   // freeze, e.g. core halted
  output logic     match_o
);

  localparam int OFS_W = `APB_SLV_SEL_LSB;

  logic                   enable_q;
  logic [`APB_DATA_W-1:0] count_q;
  logic [`APB_DATA_W-1:0] cmp_q;
  logic [`APB_DATA_W-1:0] count_inc;
  logic [OFS_W-1:0]       reg_ofs;
  logic                   apb_wr;
  logic                   cnt_wr;
  logic                   run;
  logic                   hit;

  assign reg_ofs   = apb_req_i.paddr[OFS_W-1:0];
  assign apb_wr    = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite;
  assign cnt_wr    = apb_wr & (reg_ofs == `TIMER_CNT_OFS);
  assign run       = tick_i & enable_q & ~stop_timer_i;
  assign count_inc = count_q + 1'b1;
  assign hit       = run & (count_inc == cmp_q);   // next value reaches compare

  // config and compare regs
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      enable_q <= 1'b0;
      cmp_q    <= '0;
    end else if (apb_wr) begin
      case (reg_ofs)
        `TIMER_CFG_OFS: enable_q <= apb_req_i.pwdata[0];
        `TIMER_CMP_OFS: cmp_q    <= apb_req_i.pwdata;
        default: ;
      endcase
    end
  end

  // counter, a bus write beats the tick
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      count_q <= '0;
      match_o <= 1'b0;
    end else begin
      match_o <= hit & ~cnt_wr;   // high while count reads back 0
      if (cnt_wr) begin
        count_q <= apb_req_i.pwdata;
      end else if (hit) begin
        count_q <= '0;            // wrap on match
      end else if (run) begin
        count_q <= count_inc;
      end
    end
  end

  always_comb begin
    apb_rsp_o.pready  = 1'b1;
    apb_rsp_o.pslverr = 1'b0;
    case (reg_ofs)
      `TIMER_CFG_OFS: apb_rsp_o.prdata = {{(`APB_DATA_W-1){1'b0}}, enable_q};
      `TIMER_CNT_OFS: apb_rsp_o.prdata = count_q;
      `TIMER_CMP_OFS: apb_rsp_o.prdata = cmp_q;
      default:        apb_rsp_o.prdata = '0;
    endcase
  end

endmodule

`default_nettype wire

/* event_dispatch_fsm.sv */
`timescale 1ns/10ps
`default_nettype none

`include "soc_periph_params.svh"

module event_dispatch_fsm import soc_periph_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  apb_req_t  apb_req_i,
  output apb_rsp_t  apb_rsp_o,
  input  evt_vec_t  events_i,      // raw sources, one cycle pulses
  output logic      push_valid_o,  // towards the fifo
  output event_id_t push_id_o,
  input  logic      push_ready_i
);

  localparam int OFS_W = `APB_SLV_SEL_LSB;

  typedef enum logic {
    SCAN,
    OFFER
  } state_e;

  state_e           state_q;
  evt_vec_t         mask_q;
  evt_vec_t         pend_q;
  evt_vec_t         pend_set;
  evt_vec_t         pend_clr;
  event_id_t        id_q;      // id on offer
  event_id_t        low_idx;   // lowest pending index
  logic [OFS_W-1:0] reg_ofs;
  logic             apb_wr;

  assign reg_ofs = apb_req_i.paddr[OFS_W-1:0];
  assign apb_wr  = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite;

  always_comb begin
    pend_set = events_i & mask_q;
    if (apb_wr && reg_ofs == `EVT_SW_OFS) begin
      pend_set = pend_set | apb_req_i.pwdata[`NUM_EVT-1:0];   // sw bits skip the mask
    end
    // handshake retires the bit on offer
    pend_clr = (state_q == OFFER && push_ready_i) ? (evt_vec_t'(1) << id_q) : '0;
  end

  // priority encoder, index 0 wins
  always_comb begin
    low_idx = '0;
    for (int i = `NUM_EVT - 1; i >= 0; i--) begin
      if (pend_q[i]) begin
        low_idx = event_id_t'(i);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mask_q <= '0;
      pend_q <= '0;
    end else begin
      if (apb_wr && reg_ofs == `EVT_MASK_OFS) begin
        mask_q <= apb_req_i.pwdata[`NUM_EVT-1:0];
      end
      pend_q <= (pend_q & ~pend_clr) | pend_set;   // a repeat merges into the set bit
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // dispatch FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= SCAN;
      id_q    <= '0;
    end else begin
      case (state_q)
        SCAN: begin
          if (|pend_q) begin
            id_q    <= low_idx;
            state_q <= OFFER;
          end
        end
        OFFER: begin
          if (push_ready_i) begin
            state_q <= SCAN;   // valid held until here
          end
        end
        default: state_q <= SCAN;
      endcase
    end
  end

  assign push_valid_o = (state_q == OFFER);
  assign push_id_o    = id_q;

  always_comb begin
    apb_rsp_o.pready  = 1'b1;
    apb_rsp_o.pslverr = 1'b0;
    case (reg_ofs)
      `EVT_MASK_OFS: apb_rsp_o.prdata = `APB_DATA_W'(mask_q);
      `EVT_PEND_OFS: apb_rsp_o.prdata = `APB_DATA_W'(pend_q);
      default:       apb_rsp_o.prdata = '0;   // sw reg reads zero
    endcase
  end

endmodule

`default_nettype wire

/* event_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

`include "soc_periph_params.svh"

module event_fifo import soc_periph_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      push_valid_i,
  input  event_id_t push_id_i,
  output logic      push_ready_o,
  output logic      pop_valid_o,   // cluster event side
  output event_id_t pop_id_o,
  input  logic      pop_ready_i
);

  localparam int DEPTH = `EVT_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  event_id_t        mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;   // occupancy
  logic             push;
  logic             pop;
  logic             full;

  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full         = (count_q == CNT_W'(DEPTH));
  assign push_ready_o = ~full | pop_ready_i;   // full still takes one while popping
  assign pop_valid_o  = (count_q != '0);
  assign pop_id_o     = mem_q[rd_ptr_q];       // show-ahead
  assign push         = push_valid_i & push_ready_o;
  assign pop          = pop_valid_o & pop_ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_id_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;   // both or neither
      endcase
    end
  end

endmodule

`default_nettype wire

/* soc_periph_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "soc_periph_params.svh"

module soc_periph_top import soc_periph_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    ref_clk_i,      // slow reference clock
  input  logic                    stop_timer_i,
  input  logic [`NUM_PER_EVT-1:0] per_events_i,
  input  apb_req_t                apb_req_i,
  output apb_rsp_t                apb_rsp_o,
  output logic                    cl_event_valid_o,
  output event_id_t               cl_event_data_o,
  input  logic                    cl_event_ready_i,
  output fc_events_t              fc_events_o
);

  apb_req_t  timer_req;
  apb_rsp_t  timer_rsp;
  apb_req_t  evt_req;
  apb_rsp_t  evt_rsp;
  logic      ref_rise;
  logic      ref_fall;
  logic      timer_match;
  logic      push_valid;
  logic      push_ready;
  event_id_t push_id;
  evt_vec_t  evt_src;     // all event sources, raw

  always_comb begin
    evt_src                      = '0;   // 11 and up come from sw only
    evt_src[`NUM_PER_EVT-1:0]    = per_events_i;
    evt_src[`EVT_IDX_TIMER]      = timer_match;
    evt_src[`EVT_IDX_REF_RISE]   = ref_rise;
    evt_src[`EVT_IDX_REF_FALL]   = ref_fall;
    // fc word mirrors the sources plus fifo not empty
    fc_events_o                     = fc_events_t'(evt_src);
    fc_events_o[`FC_IDX_FIFO_VALID] = cl_event_valid_o;
  end

  ////////////////////////////////////////////////////////////////////////////
  // apb decode and register blocks
  ////////////////////////////////////////////////////////////////////////////

  apb_periph_decode apb_periph_decode_inst (
    .apb_req_i   (apb_req_i),
    .apb_rsp_o   (apb_rsp_o),
    .timer_req_o (timer_req),
    .timer_rsp_i (timer_rsp),
    .evt_req_o   (evt_req),
    .evt_rsp_i   (evt_rsp)
  );

  ref_clk_edge_detect ref_clk_edge_detect_inst (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .ref_clk_i (ref_clk_i),
    .rise_o    (ref_rise),
    .fall_o    (ref_fall)
  );

  soc_timer_unit soc_timer_unit_inst (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .apb_req_i    (timer_req),
    .apb_rsp_o    (timer_rsp),
    .tick_i       (ref_rise),      // counts ref clk rises
    .stop_timer_i (stop_timer_i),
    .match_o      (timer_match)
  );

  ////////////////////////////////////////////////////////////////////////////
  // event path, dispatcher into fifo into cluster port
  ////////////////////////////////////////////////////////////////////////////

  event_dispatch_fsm event_dispatch_fsm_inst (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .apb_req_i    (evt_req),
    .apb_rsp_o    (evt_rsp),
    .events_i     (evt_src),
    .push_valid_o (push_valid),
    .push_id_o    (push_id),
    .push_ready_i (push_ready)
  );

  event_fifo event_fifo_inst (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .push_valid_i (push_valid),
    .push_id_i    (push_id),
    .push_ready_o (push_ready),
    .pop_valid_o  (cl_event_valid_o),
    .pop_id_o     (cl_event_data_o),
    .pop_ready_i  (cl_event_ready_i)
  );

endmodule

`default_nettype wire

/* tb_soc_periph.sv */
`timescale 1ns/10ps
`default_nettype none

`include "soc_periph_params.svh"

module tb_soc_periph import soc_periph_pkg::*; ();

  // register addresses as block field over offset
  localparam logic [11:0] A_TMR_CFG  = {4'h0, `TIMER_CFG_OFS};
  localparam logic [11:0] A_TMR_CNT  = {4'h0, `TIMER_CNT_OFS};
  localparam logic [11:0] A_TMR_CMP  = {4'h0, `TIMER_CMP_OFS};
  localparam logic [11:0] A_EVT_MASK = {4'h1, `EVT_MASK_OFS};
  localparam logic [11:0] A_EVT_SW   = {4'h1, `EVT_SW_OFS};
  localparam logic [11:0] A_EVT_PEND = {4'h1, `EVT_PEND_OFS};

  typedef enum logic [3:0] {
    OP_WR,       // apb write
    OP_RD,       // apb read and compare
    OP_PULSE,    // one cycle random per_events_i
    OP_READY,    // hold cl_event_ready_i
    OP_EXPECT,   // add an id to the scoreboard
    OP_WAIT,     // drain events and ref toggles
    OP_REF,      // request ref_clk_i toggles
    OP_STOP,     // drive stop_timer_i
    OP_FC        // idle cycles then compare fc word
  } op_e;

  typedef struct packed {
    op_e         op;
    logic [11:0] addr;
    logic [31:0] data;
    logic [31:0] exp;
  } row_t;

  logic                    clk_i;
  logic                    rst_n_i;
  logic                    ref_clk_i;
  logic                    stop_timer_i;
  logic [`NUM_PER_EVT-1:0] per_events_i;
  apb_req_t                apb_req;
  apb_rsp_t                apb_rsp_o;
  logic                    cl_event_valid_o;
  event_id_t               cl_event_data_o;
  logic                    cl_event_ready_i;
  fc_events_t              fc_events_o;

  row_t      rows [128];
  int        n_rows = 0;
  event_id_t sb_ids [256];   // scoreboard fed by main and drained by the monitor
  int        sb_wr = 0;
  int        sb_rd = 0;
  logic [15:0] mask_model;   // what EVT_MASK should hold
  integer    seed = 9;
  int        ref_req = 0;    // toggles asked for
  int        ref_done = 0;   // toggles made
  int        ref_div = 0;
  int        ref_rises = 0;
  int        cycle_cnt = 0;
  int        err_cnt = 0;     // bus and fc checks
  int        chk_cnt = 0;
  int        ev_err_cnt = 0;  // event port checks
  int        ev_chk_cnt = 0;
  int        last_match_rises = 0;
  logic      prev_valid = 1'b0;
  logic      prev_ready = 1'b0;
  event_id_t prev_data = '0;

  soc_periph_top soc_periph_top_inst (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .ref_clk_i        (ref_clk_i),
    .stop_timer_i     (stop_timer_i),
    .per_events_i     (per_events_i),
    .apb_req_i        (apb_req),
    .apb_rsp_o        (apb_rsp_o),
    .cl_event_valid_o (cl_event_valid_o),
    .cl_event_data_o  (cl_event_data_o),
    .cl_event_ready_i (cl_event_ready_i),
    .fc_events_o      (fc_events_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // one ref clock toggle per 8 cycles while requested
  initial begin
    ref_clk_i = 1'b0;
    forever begin
      @(negedge clk_i);
      if (ref_done < ref_req) begin
        ref_div++;
        if (ref_div == 8) begin
          ref_div   = 0;
          ref_clk_i = ~ref_clk_i;
          ref_done++;
          if (ref_clk_i) ref_rises++;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_apb_rsp(input apb_rsp_t got, input apb_rsp_t exp, input string what);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[ERROR] %0t: %s got prdata %h pready %b pslverr %b, expected %h %b %b",
               $time, what, got.prdata, got.pready, got.pslverr,
               exp.prdata, exp.pready, exp.pslverr);
    end
  endtask

  task automatic check_fc(input fc_events_t got, input fc_events_t exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[ERROR] %0t: fc_events_o is %h, expected %h", $time, got, exp);
    end
  endtask

  // popped id against the oldest scoreboard entry
  task automatic check_event(input event_id_t got);
    ev_chk_cnt++;
    if (sb_rd == sb_wr) begin
      ev_err_cnt++;
      $display("[ERROR] %0t: event id %0d arrived with none expected", $time, got);
    end else begin
      if (got !== sb_ids[sb_rd]) begin
        ev_err_cnt++;
        $display("[ERROR] %0t: event id %0d, expected %0d", $time, got, sb_ids[sb_rd]);
      end
      sb_rd++;
    end
  endtask

  // cluster port monitor sees the handshake at the clock edge
  always @(posedge clk_i) begin
    if (rst_n_i) begin
      if (prev_valid && !prev_ready && (!cl_event_valid_o || cl_event_data_o != prev_data)) begin
        ev_err_cnt++;
        $display("[ERROR] %0t: cluster event dropped or changed before ready", $time);
      end
      if (cl_event_valid_o && cl_event_ready_i) begin
        if (cl_event_data_o == event_id_t'(`EVT_IDX_TIMER)) begin
          ev_chk_cnt++;
          if (ref_rises - last_match_rises != 3) begin   // cmp is 3 in the timer phase
            ev_err_cnt++;
            $display("[ERROR] %0t: timer event after %0d ref rises, expected 3",
                     $time, ref_rises - last_match_rises);
          end
          last_match_rises = ref_rises;
        end
        check_event(cl_event_data_o);
      end
      prev_valid = cl_event_valid_o;
      prev_ready = cl_event_ready_i;
      prev_data  = cl_event_data_o;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic push_id(input event_id_t id);
    sb_ids[sb_wr] = id;
    sb_wr++;
  endtask

  // dispatch goes lowest index first
  task automatic push_bits(input logic [15:0] bits);
    for (int i = 0; i < `NUM_EVT; i++) begin
      if (bits[i]) push_id(event_id_t'(i));
    end
  endtask

  // setup then access with zero wait states
  task automatic apb_access(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                            output apb_rsp_t rsp);
    @(negedge clk_i);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(negedge clk_i);
    apb_req.penable = 1'b1;
    #1 rsp = apb_rsp_o;   // comb read data of the access phase
    @(posedge clk_i);
    @(negedge clk_i);
    apb_req = '0;
  endtask

  task automatic add_row(input op_e op, input logic [11:0] addr, input logic [31:0] data,
                         input logic [31:0] exp);
    rows[n_rows] = '{op, addr, data, exp};
    n_rows++;
  endtask

  task automatic load_table();
    // reset values
    add_row(OP_RD, A_TMR_CMP, 0, 0);
    add_row(OP_RD, A_EVT_MASK, 0, 0);
    add_row(OP_FC, 12'h000, 0, 0);
    // register access and holes in the map
    add_row(OP_WR, A_TMR_CMP, 32'h0000_1234, 0);
    add_row(OP_RD, A_TMR_CMP, 0, 32'h0000_1234);
    add_row(OP_WR, A_EVT_MASK, 32'h0000_F0F0, 0);
    add_row(OP_RD, A_EVT_MASK, 0, 32'h0000_F0F0);
    add_row(OP_RD, 12'h20C, 0, 0);
    add_row(OP_RD, 12'hF00, 0, 0);
    add_row(OP_WR, A_TMR_CMP, 0, 0);
    // software events
    add_row(OP_WR, A_EVT_SW, 32'h0000_8025, 0);
    add_row(OP_WAIT, 12'h000, 0, 0);
    add_row(OP_RD, A_EVT_PEND, 0, 0);
    add_row(OP_WR, A_EVT_SW, 32'h0000_0A10, 0);
    add_row(OP_WAIT, 12'h000, 0, 0);
    add_row(OP_RD, A_EVT_PEND, 0, 0);
    // mask against random peripheral pulses
    add_row(OP_WR, A_EVT_MASK, 32'h0000_00A5, 0);
    add_row(OP_RD, A_EVT_MASK, 0, 32'h0000_00A5);
    for (int i = 0; i < 8; i++) begin
      add_row(OP_PULSE, 12'h000, 0, 0);
      add_row(OP_WAIT, 12'h000, 0, 0);
    end
    add_row(OP_FC, 12'h000, 2, 0);
    // back-pressure leaves 4 in the fifo with 12 on offer and 15 pending
    add_row(OP_READY, 12'h000, 0, 0);
    add_row(OP_WR, A_EVT_SW, 32'h0000_905A, 0);
    add_row(OP_FC, 12'h000, 20, 32'h0000_0800);
    add_row(OP_RD, A_EVT_PEND, 0, 32'h0000_9000);
    add_row(OP_READY, 12'h000, 1, 0);
    add_row(OP_WAIT, 12'h000, 0, 0);
    add_row(OP_RD, A_EVT_PEND, 0, 0);
    // timer match every third rise
    add_row(OP_WR, A_EVT_MASK, 32'h0000_0100, 0);
    add_row(OP_WR, A_TMR_CMP, 3, 0);
    add_row(OP_WR, A_TMR_CFG, 1, 0);
    add_row(OP_RD, A_TMR_CFG, 0, 1);
    add_row(OP_EXPECT, 12'h000, `EVT_IDX_TIMER, 0);
    add_row(OP_EXPECT, 12'h000, `EVT_IDX_TIMER, 0);
    add_row(OP_REF, 12'h000, 12, 0);                 // six rises
    add_row(OP_WAIT, 12'h000, 0, 0);
    add_row(OP_RD, A_TMR_CNT, 0, 0);
    // ref edges as events
    add_row(OP_WR, A_EVT_MASK, 32'h0000_0600, 0);
    add_row(OP_EXPECT, 12'h000, `EVT_IDX_REF_RISE, 0);
    add_row(OP_EXPECT, 12'h000, `EVT_IDX_REF_FALL, 0);
    add_row(OP_EXPECT, 12'h000, `EVT_IDX_REF_RISE, 0);
    add_row(OP_EXPECT, 12'h000, `EVT_IDX_REF_FALL, 0);
    add_row(OP_REF, 12'h000, 4, 0);
    add_row(OP_WAIT, 12'h000, 0, 0);
    add_row(OP_RD, A_TMR_CNT, 0, 2);                 // two more rises
    // stop_timer_i freezes the count
    add_row(OP_WR, A_EVT_MASK, 0, 0);
    add_row(OP_STOP, 12'h000, 1, 0);
    add_row(OP_REF, 12'h000, 4, 0);
    add_row(OP_RD, A_TMR_CNT, 0, 2);
    add_row(OP_WAIT, 12'h000, 0, 0);
    add_row(OP_RD, A_TMR_CNT, 0, 2);
    add_row(OP_STOP, 12'h000, 0, 0);
    add_row(OP_FC, 12'h000, 2, 0);
  endtask

  task automatic apply_row(input row_t row);
    apb_rsp_t    rsp;
    apb_rsp_t    exp_rsp;
    logic [31:0] rnd;
    logic [7:0]  pat;
    logic        unmapped;
    case (row.op)
      OP_WR: begin
        if (row.addr == A_EVT_SW) push_bits(row.data[15:0]);     // sw bits bypass the mask
        if (row.addr == A_EVT_MASK) mask_model = row.data[15:0];
        apb_access(1'b1, row.addr, row.data, rsp);
      end
      OP_RD: begin
        unmapped = (row.addr[`APB_ADDR_W-1:`APB_SLV_SEL_LSB] > 4'h1);
        apb_access(1'b0, row.addr, 32'h0, rsp);
        exp_rsp.prdata  = unmapped ? 32'h0 : row.exp;
        exp_rsp.pready  = 1'b1;
        exp_rsp.pslverr = unmapped;
        check_apb_rsp(rsp, exp_rsp, $sformatf("read of %h", row.addr));
      end
      OP_PULSE: begin
        @(negedge clk_i);
        rnd = $random(seed);
        pat = rnd[7:0];
        per_events_i = pat;
        push_bits({8'h00, pat & mask_model[7:0]});
        #1 check_fc(fc_events_o, {8'h00, pat});   // fifo drained so bit 11 is low
        @(negedge clk_i);
        per_events_i = '0;
      end
      OP_READY: begin
        @(negedge clk_i);
        cl_event_ready_i = row.data[0];
      end
      OP_EXPECT: push_id(event_id_t'(row.data));
      OP_WAIT: begin
        while (!(sb_rd == sb_wr && !cl_event_valid_o && ref_done == ref_req)) begin
          @(negedge clk_i);
        end
      end
      OP_REF: ref_req = ref_req + int'(row.data);
      OP_STOP: begin
        @(negedge clk_i);
        stop_timer_i = row.data[0];
      end
      OP_FC: begin
        repeat (row.data) @(negedge clk_i);
        #1 check_fc(fc_events_o, row.exp[15:0]);
      end
      default: ;
    endcase
  endtask

  task automatic print_counts();
    $display("result: %0d checks, %0d errors", chk_cnt + ev_chk_cnt, err_cnt + ev_err_cnt);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence and timeout
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst_n_i          = 1'b0;
    stop_timer_i     = 1'b0;
    per_events_i     = '0;
    apb_req          = '0;
    cl_event_ready_i = 1'b1;
    mask_model       = '0;
    load_table();
    repeat (3) @(negedge clk_i);   // three cycles in reset
    rst_n_i = 1'b1;
    for (int r = 0; r < n_rows; r++) begin
      apply_row(rows[r]);
    end
    if (sb_rd != sb_wr) begin
      err_cnt++;
      $display("[ERROR] %0t: %0d expected event ids never arrived", $time, sb_wr - sb_rd);
    end
    print_counts();
    if (err_cnt + ev_err_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // limit grows with the table
  initial begin
    while (cycle_cnt < 50 * n_rows + 2000) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("timeout: the run did not finish within %0d cycles", cycle_cnt);
    print_counts();
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+.
soc_periph_pkg.sv
apb_periph_decode.sv
ref_clk_edge_detect.sv
soc_timer_unit.sv
event_dispatch_fsm.sv
event_fifo.sv
soc_periph_top.sv
tb_soc_periph.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps -f vlog.f \
  --top-module tb_soc_periph -o tb_soc_periph

out=$(./obj_dir/tb_soc_periph)
echo "$out"

if echo "$out" | grep -qx "ALL CHECKS PASSED"; then
  exit 0
fi
exit 1
